//--- Makefile
TOP = tb_cmd_queue_wb

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f cmd_queue_wb.f -o $(TOP)
	@out="$$(./obj_dir/$(TOP))"; echo "$$out"; echo "$$out" | grep -q '^RESULT: PASS$$'

clean:
	rm -rf obj_dir

.PHONY: sim clean

//--- cmd_queue_wb.f
+incdir+hdl
hdl/cmd_queue_pkg.sv
hdl/fifo_if.sv
hdl/fifo_data.sv
hdl/sfifo2f.sv
hdl/wb_wait_timer.sv
hdl/wb_write_fsm.sv
hdl/cmd_queue_wb.sv
sim/cmd_queue_wb_properties.sv
sim/tb_cmd_queue_wb.sv

//--- hdl/cmd_queue_defs.svh
// widths, FIFO depth and bus watchdog limit for the write-command queue
// include wherever a default parameter or type width is needed
`ifndef CQ_DEFS_SVH
`define CQ_DEFS_SVH

// wishbone address width
`define CQ_ADDR_W 16

// wishbone data width
`define CQ_DATA_W 32

// FIFO pointer bits, depth is 2**bits
`define CQ_DEPTH_NBITS 1

// cycles in ST_BUS without ack before the write is abandoned
`define CQ_WAIT_LIMIT 8

`endif

//--- hdl/cmd_queue_pkg.sv
// shared types for the write-command queue
// compile after the defs header and before every design unit
`include "cmd_queue_defs.svh"

package cmd_queue_pkg;

	// bus fields
	typedef logic [`CQ_ADDR_W-1:0] addr_t;
	typedef logic [`CQ_DATA_W-1:0] data_t;

	// FIFO word, address in the upper bits
	typedef logic [`CQ_ADDR_W+`CQ_DATA_W-1:0] cmd_t;

	// FIFO pointer and fill level
	typedef logic [`CQ_DEPTH_NBITS-1:0] ptr_t;
	typedef logic [`CQ_DEPTH_NBITS:0] count_t;

	// watchdog count, wide enough for the wait limit
	typedef logic [3:0] wait_t;

	// write sequencer states
	typedef enum logic [1:0] {ST_IDLE, ST_BUS, ST_DONE} wb_state_t;

endpackage

//--- hdl/cmd_queue_wb.sv
// top of the write-command queue, host valid/ready in, wishbone classic out
// FIFO, write sequencer and bus watchdog joined here
`timescale 1ns/10ps
`include "cmd_queue_defs.svh"

module cmd_queue_wb (
	input logic clk,
	input logic rst_n,
	// host push side
	input logic cmd_valid,
	input cmd_queue_pkg::addr_t cmd_addr,
	input cmd_queue_pkg::data_t cmd_data,
	output logic cmd_ready,
	output cmd_queue_pkg::count_t fill_count,
	// wishbone master
	output logic wb_cyc,
	output logic wb_stb,
	output logic wb_we,
	output cmd_queue_pkg::addr_t wb_adr,
	output cmd_queue_pkg::data_t wb_dat_o,
	input logic wb_ack,
	// status
	output logic busy,
	output logic timeout_err
);

	// watchdog handshake
	logic tmr_start;
	logic tmr_run;
	logic tmr_expired;

	fifo_if #(.DEPTH_NBITS(`CQ_DEPTH_NBITS)) cq_if ();

	// push side straight from the host, host honours cmd_ready
	assign cq_if.wr = cmd_valid;
	assign cq_if.din = {cmd_addr, cmd_data};
	assign cmd_ready = ~cq_if.full;
	assign fill_count = cq_if.count;

	sfifo2f u_fifo (
		.clk(clk),
		.rst_n(rst_n),
		.q(cq_if.fifo)
	);

	wb_wait_timer #(.LIMIT(`CQ_WAIT_LIMIT)) u_timer (
		.clk(clk),
		.rst_n(rst_n),
		.start(tmr_start),
		.run(tmr_run),
		.expired(tmr_expired)
	);

	wb_write_fsm u_fsm (
		.clk(clk),
		.rst_n(rst_n),
		.q(cq_if.pop),
		.wb_cyc(wb_cyc),
		.wb_stb(wb_stb),
		.wb_we(wb_we),
		.wb_adr(wb_adr),
		.wb_dat_o(wb_dat_o),
		.wb_ack(wb_ack),
		.tmr_start(tmr_start),
		.tmr_run(tmr_run),
		.tmr_expired(tmr_expired),
		.busy(busy),
		.timeout_err(timeout_err)
	);

endmodule

//--- hdl/fifo_data.sv
// flop storage for the small synchronous FIFO
// written at wptr on wr, read combinationally at rptr
`timescale 1ns/10ps
`include "cmd_queue_defs.svh"

module fifo_data #(
	parameter int WIDTH = `CQ_ADDR_W + `CQ_DATA_W,
	parameter int DEPTH_NBITS = `CQ_DEPTH_NBITS
) (
	input logic clk,
	input cmd_queue_pkg::ptr_t wptr,
	input cmd_queue_pkg::ptr_t rptr,
	input logic wr,
	input logic [WIDTH-1:0] din,
	output logic [WIDTH-1:0] dout
);

	localparam int DEPTH = 1 << DEPTH_NBITS;

	// storage only, contents undefined after reset
	logic [WIDTH-1:0] mem [DEPTH];

	always_ff @(posedge clk) begin
		if (wr) begin
			mem[wptr] <= din;
		end
	end

	// word at the head, valid in the pop cycle
	assign dout = mem[rptr];

endmodule

//--- hdl/fifo_if.sv
// FIFO connection between the command producer, the FIFO and the consumer
// instantiated once in the top level
`timescale 1ns/10ps
`include "cmd_queue_defs.svh"

interface fifo_if #(parameter int DEPTH_NBITS = `CQ_DEPTH_NBITS);
	import cmd_queue_pkg::*;

	// producer side
	logic wr;
	cmd_t din;

	// consumer side
	logic rd;
	cmd_t dout;

	// status, all registered in the FIFO
	logic empty;
	logic full;
	logic fullm1;
	logic emptyp2;
	logic [DEPTH_NBITS:0] count;

	modport fifo (input wr, din, rd, output dout, empty, full, fullm1, emptyp2, count);
	modport push (output wr, din, input full, fullm1, count);
	modport pop (output rd, input dout, empty, emptyp2);
endinterface

//--- hdl/sfifo2f.sv
// two-deep synchronous FIFO built from flops
// all status flags and the fill count are registered
`timescale 1ns/10ps
`include "cmd_queue_defs.svh"

module sfifo2f #(
	parameter int WIDTH = `CQ_ADDR_W + `CQ_DATA_W,
	parameter int DEPTH_NBITS = `CQ_DEPTH_NBITS
) (
	input logic clk,
	input logic rst_n,
	fifo_if.fifo q
);
	import cmd_queue_pkg::*;

	localparam int DEPTH = 1 << DEPTH_NBITS;
	localparam int MAXM1 = DEPTH - 1;

	// ==================================================================
	// pointers and next count
	// ==================================================================

	ptr_t rptr;
	ptr_t wptr;
	ptr_t nrptr;
	ptr_t nwptr;
	count_t count_r;
	count_t ncount;

	// pointers wrap naturally at the depth
	assign nrptr = rptr + ptr_t'(q.rd);
	assign nwptr = wptr + ptr_t'(q.wr);

	// no overflow or underflow guard here
	assign ncount = count_r + count_t'(q.wr) - count_t'(q.rd);

	assign q.count = count_r;

	// storage
	fifo_data #(
		.WIDTH(WIDTH),
		.DEPTH_NBITS(DEPTH_NBITS)
	) u_fifo_data (
		.clk(clk),
		.wptr(wptr),
		.rptr(rptr),
		.wr(q.wr),
		.din(q.din),
		.dout(q.dout)
	);

	// ==================================================================
	// registered state and flags
	// ==================================================================

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			rptr <= '0;
			wptr <= '0;
			count_r <= '0;
			q.full <= 1'b0;
			q.empty <= 1'b1;
			q.fullm1 <= 1'b0;
			q.emptyp2 <= 1'b0;
		end else begin
			rptr <= nrptr;
			wptr <= nwptr;
			count_r <= ncount;
			// flags from the next count, so they line up with count
			q.full <= (ncount == count_t'(DEPTH));
			q.empty <= (ncount == '0);
			// one below full
			q.fullm1 <= (ncount == count_t'(MAXM1));
			// exactly two words held
			q.emptyp2 <= (ncount == count_t'(2));
		end
	end

endmodule

//--- hdl/wb_wait_timer.sv
// bus watchdog for the wishbone write sequencer
// load on start, count down while run, pulse expired at the last count
`timescale 1ns/10ps
`include "cmd_queue_defs.svh"

module wb_wait_timer #(
	parameter int LIMIT = `CQ_WAIT_LIMIT
) (
	input logic clk,
	input logic rst_n,
	input logic start,
	input logic run,
	output logic expired
);
	import cmd_queue_pkg::*;

	// cycles left in the current bus cycle
	wait_t cnt;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			cnt <= '0;
		end else if (start) begin
			cnt <= wait_t'(LIMIT);
		end else if (run && cnt != '0) begin
			cnt <= cnt - 1'b1;
		end
	end

	// high in the LIMIT-th run cycle after a start
	assign expired = run && (cnt == wait_t'(1));

endmodule

//--- hdl/wb_write_fsm.sv
// pops write commands from the FIFO and runs wishbone classic write cycles
// a cycle ends on wb_ack or on watchdog expiry, expiry sets a sticky error
`timescale 1ns/10ps

module wb_write_fsm (
	input logic clk,
	input logic rst_n,
	fifo_if.pop q,
	output logic wb_cyc,
	output logic wb_stb,
	output logic wb_we,
	output cmd_queue_pkg::addr_t wb_adr,
	output cmd_queue_pkg::data_t wb_dat_o,
	input logic wb_ack,
	output logic tmr_start,
	output logic tmr_run,
	input logic tmr_expired,
	output logic busy,
	output logic timeout_err
);
	import cmd_queue_pkg::*;

	wb_state_t state;

	// head of the FIFO split into its fields
	addr_t pop_adr;
	data_t pop_dat;

	// cycle finished, either way
	logic bus_end;

	assign {pop_adr, pop_dat} = q.dout;

	// pop straight from idle, the read data is already valid
	assign q.rd = (state == ST_IDLE) && !q.empty;

	// watchdog loads on the pop edge and counts during ST_BUS
	assign tmr_start = q.rd;
	assign tmr_run = (state == ST_BUS);

	assign bus_end = (state == ST_BUS) && (wb_ack || tmr_expired);

	assign busy = (state != ST_IDLE);

	// ==================================================================
	// control
	// ==================================================================

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state <= ST_IDLE;
			wb_cyc <= 1'b0;
			wb_stb <= 1'b0;
			wb_we <= 1'b0;
			timeout_err <= 1'b0;
		end else begin
			case (state)
				ST_IDLE: begin
					if (q.rd) begin
						// cyc, stb and we rise together
						state <= ST_BUS;
						wb_cyc <= 1'b1;
						wb_stb <= 1'b1;
						wb_we <= 1'b1;
					end
				end
				ST_BUS: begin
					if (bus_end) begin
						state <= ST_DONE;
						wb_cyc <= 1'b0;
						wb_stb <= 1'b0;
						wb_we <= 1'b0;
						// late ack in the expiry cycle still counts as good
						if (!wb_ack) begin
							timeout_err <= 1'b1;
						end
					end
				end
				// one idle bus cycle between writes
				ST_DONE: state <= ST_IDLE;
				default: state <= ST_IDLE;
			endcase
		end
	end

	// ==================================================================
	// payload, held for the whole cycle
	// ==================================================================

	always_ff @(posedge clk) begin
		if (q.rd) begin
			wb_adr <= pop_adr;
			wb_dat_o <= pop_dat;
		end
	end

endmodule

//--- sim/cmd_queue_wb_input.txt
# name  addr(hex)  data(hex)  slave_wait(dec, 255 never acks, 254 random)
# push_gap(dec, idle cycles before the push, 0 joins the previous push back to back)
single      1000  a5a50001  2    3
burst_0     2000  11110000  6    2
burst_1     2004  22220001  6    0
burst_2     2008  33330002  6    0
rand_0      3000  deadbe00  254  2
rand_1      3004  deadbe01  254  0
rand_2      3008  deadbe02  254  0
rand_3      300c  deadbe03  254  0
rand_4      3010  deadbe04  254  0
hang        4000  0badf00d  255  2
after_hang  4004  c0ffee01  1    2

//--- sim/cmd_queue_wb_properties.sv
// protocol rules for the host push side, the FIFO and the wishbone master
// attached to every cmd_queue_wb instance by the bind at the end of this file
`timescale 1ns/10ps

module cmd_queue_wb_properties (
	input logic clk,
	input logic rst_n,
	input logic cmd_valid,
	input logic cmd_ready,
	input logic pop_rd,
	input logic fifo_empty,
	input logic fifo_fullm1,
	input logic fifo_emptyp2,
	input logic wb_cyc,
	input logic wb_stb,
	input logic wb_ack,
	input cmd_queue_pkg::addr_t wb_adr,
	input cmd_queue_pkg::data_t wb_dat_o
);

	// assertion failures seen so far
	int fail_cnt = 0;

	// words held according to the push and pop handshakes
	int held;

	always @(posedge clk) begin
		if (!rst_n) begin
			held <= 0;
		end else begin
			held <= held + int'(cmd_valid && cmd_ready) - int'(pop_rd);
		end
	end

	// ==================================================================
	// FIFO side
	// ==================================================================

	// host holds off while full
	a_no_push_full: assert property (@(posedge clk) disable iff (!rst_n)
		!(cmd_valid && !cmd_ready))
		else begin
			$error("command pushed while the FIFO was full");
			fail_cnt++;
		end

	a_no_pop_empty: assert property (@(posedge clk) disable iff (!rst_n)
		!(pop_rd && held == 0))
		else begin
			$error("FIFO popped while empty");
			fail_cnt++;
		end

	// level flags against the handshake count
	a_level_flags: assert property (@(posedge clk) disable iff (!rst_n)
		(fifo_empty == (held == 0)) && (fifo_fullm1 == (held == 1))
		&& (fifo_emptyp2 == (held == 2)))
		else begin
			$error("FIFO level flags disagree with the words held");
			fail_cnt++;
		end

	// ==================================================================
	// wishbone classic
	// ==================================================================

	a_stb_in_cyc: assert property (@(posedge clk) disable iff (!rst_n)
		wb_stb |-> wb_cyc)
		else begin
			$error("wb_stb high outside a cycle");
			fail_cnt++;
		end

	// payload frozen until the slave answers
	a_payload_stable: assert property (@(posedge clk) disable iff (!rst_n)
		(wb_stb && !wb_ack) |=> (!wb_stb || ($stable(wb_adr) && $stable(wb_dat_o))))
		else begin
			$error("address or data moved during a write");
			fail_cnt++;
		end

	a_cyc_drop: assert property (@(posedge clk) disable iff (!rst_n)
		(wb_cyc && wb_ack) |=> !wb_cyc)
		else begin
			$error("wb_cyc still high after the acknowledge");
			fail_cnt++;
		end

endmodule

bind cmd_queue_wb cmd_queue_wb_properties u_props (
	.clk(clk),
	.rst_n(rst_n),
	.cmd_valid(cmd_valid),
	.cmd_ready(cmd_ready),
	.pop_rd(cq_if.rd),
	.fifo_empty(cq_if.empty),
	.fifo_fullm1(cq_if.fullm1),
	.fifo_emptyp2(cq_if.emptyp2),
	.wb_cyc(wb_cyc),
	.wb_stb(wb_stb),
	.wb_ack(wb_ack),
	.wb_adr(wb_adr),
	.wb_dat_o(wb_dat_o)
);

//--- sim/tb_cmd_queue_wb.sv
// write-command queue testbench driven by the stimulus file
// acts as the wishbone slave and checks every write that reaches the bus
`timescale 1ns/10ps
`include "cmd_queue_defs.svh"

module tb_cmd_queue_wb;
	import cmd_queue_pkg::*;

	localparam time CLK_PERIOD = 100ns;
	localparam int SEED = 33;
	localparam int WAIT_TMO = 400;
	localparam int MAX_TESTS = 32;
	// slave wait codes in the input file
	localparam int NO_ACK = 255;
	localparam int RAND_ACK = 254;
	// push edge through the first edge that samples wb_stb, both counted
	localparam int LAT_EDGES = 3;

	logic clk, rst_n, cmd_valid, cmd_ready, wb_cyc, wb_stb, wb_we, wb_ack, busy, timeout_err;
	addr_t cmd_addr, wb_adr;
	data_t cmd_data, wb_dat_o;
	count_t fill_count;

	// test table from the input file
	string t_name [MAX_TESTS];
	addr_t t_adr [MAX_TESTS];
	data_t t_dat [MAX_TESTS];
	int t_wait [MAX_TESTS];
	int t_gap [MAX_TESTS];
	int n_tests = 0;

	// one entry per finished bus cycle in bus order
	addr_t c_adr [$];
	data_t c_dat [$];
	logic c_ack [$];
	int c_len [$];
	int rise_q [$];

	int cyc_cnt = 0;
	int push_edge, stb_len, cyc_low, max_fill;
	logic stb_prev, ready_fell;
	int slv_idx, slv_waited, slv_target;
	logic slv_busy;
	string cur_name = "reset";
	int test_errs = 0;
	int total_errs = 0;
	int passed = 0;
	int failed = 0;

	cmd_queue_wb DUT (
		.clk(clk),
		.rst_n(rst_n),
		.cmd_valid(cmd_valid),
		.cmd_addr(cmd_addr),
		.cmd_data(cmd_data),
		.cmd_ready(cmd_ready),
		.fill_count(fill_count),
		.wb_cyc(wb_cyc),
		.wb_stb(wb_stb),
		.wb_we(wb_we),
		.wb_adr(wb_adr),
		.wb_dat_o(wb_dat_o),
		.wb_ack(wb_ack),
		.busy(busy),
		.timeout_err(timeout_err)
	);

	initial clk = 1'b0;
	always #(CLK_PERIOD / 2) clk = ~clk;

	// rising edge number
	always @(posedge clk) cyc_cnt <= cyc_cnt + 1;

	task automatic check_val(input string test, input string what,
			input longint unsigned exp, input longint unsigned got);
		assert (exp == got) else begin
			$display("ERROR %s %s expected 0x%0h actual 0x%0h", test, what, exp, got);
			test_errs++;
		end
	endtask

	task automatic abort_run(input string what);
		$display("%s at %0t", what, $time);
		$display("RESULT: FAIL");
		$finish;
	endtask

	task automatic finish_test(input string test);
		if (test_errs == 0) begin
			passed++;
			$display("test %s: ok", test);
		end else begin
			failed++;
			$display("test %s: failed with %0d errors", test, test_errs);
		end
		total_errs += test_errs;
		test_errs = 0;
	endtask

	// queue empty and sequencer back in idle
	task automatic wait_idle();
		int n;
		n = 0;
		while (busy || fill_count != 0) begin
			@(negedge clk);
			n++;
			if (n > WAIT_TMO) abort_run("queue never went idle");
		end
	endtask

	task automatic wait_cycles(input int cnt);
		int n;
		n = 0;
		while (c_adr.size() < cnt) begin
			@(negedge clk);
			n++;
			if (n > WAIT_TMO) abort_run("bus write never finished");
		end
	endtask

	// called on a falling edge and returns on the falling edge after the push
	task automatic push_cmd(input int idx);
		int n;
		n = 0;
		while (!cmd_ready) begin
			@(negedge clk);
			n++;
			if (n > WAIT_TMO) abort_run("cmd_ready stayed low");
		end
		cmd_valid = 1'b1;
		cmd_addr = t_adr[idx];
		cmd_data = t_dat[idx];
		push_edge = cyc_cnt + 1;
		@(negedge clk);
		cmd_valid = 1'b0;
	endtask

	function automatic int pick_delay(input int idx);
		if (idx >= n_tests) return 0;
		// random waits stay below the watchdog limit
		if (t_wait[idx] == RAND_ACK) return int'($urandom % (`CQ_WAIT_LIMIT - 1));
		return t_wait[idx];
	endfunction

	// ==================================================================
	// wishbone slave acking after the wait count of the matching test
	// ==================================================================

	always @(negedge clk) begin
		if (!rst_n) begin
			wb_ack <= 1'b0;
			slv_busy = 1'b0;
			slv_idx = 0;
		end else if (!wb_stb) begin
			wb_ack <= 1'b0;
			if (slv_busy) begin
				slv_busy = 1'b0;
				slv_idx++;
			end
		end else begin
			if (!slv_busy) begin
				slv_busy = 1'b1;
				slv_waited = 0;
				slv_target = pick_delay(slv_idx);
			end
			if (slv_target != NO_ACK && slv_waited == slv_target) wb_ack <= 1'b1;
			else slv_waited++;
		end
	end

	// bus monitor recording each cycle when wb_stb falls
	always @(negedge clk) begin
		if (!rst_n) begin
			stb_prev = 1'b0;
			cyc_low = 1;
		end else begin
			if (wb_stb && !stb_prev) begin
				// next rising edge is the first to sample wb_stb
				rise_q.push_back(cyc_cnt + 1);
				stb_len = 0;
				assert (cyc_low >= 1) else begin
					$display("ERROR %s: wb_cyc did not drop between two writes", cur_name);
					test_errs++;
				end
			end
			if (wb_stb) begin
				stb_len++;
				check_val(cur_name, "wb_we", 1, wb_we);
			end else if (stb_prev) begin
				// wb_ack still holds what the closing edge sampled
				c_adr.push_back(wb_adr);
				c_dat.push_back(wb_dat_o);
				c_ack.push_back(wb_ack);
				c_len.push_back(stb_len);
			end
			cyc_low = wb_cyc ? 0 : cyc_low + 1;
			if (int'(fill_count) > max_fill) max_fill = fill_count;
			if (!cmd_ready) ready_fell = 1'b1;
			stb_prev = wb_stb;
		end
	end

	// ==================================================================
	// main sequence
	// ==================================================================

	initial begin
		int fd, w, g, i, k, grp_end, first_push;
		string line, nm;
		addr_t a;
		data_t d;
		logic hang_seen;
		void'($urandom(SEED));
		rst_n = 1'b0;
		cmd_valid = 1'b0;
		cmd_addr = '0;
		cmd_data = '0;
		wb_ack <= 1'b0;
		hang_seen = 1'b0;
		fd = $fopen("sim/cmd_queue_wb_input.txt", "r");
		if (fd == 0) abort_run("cannot open the input file");
		while ($fgets(line, fd) != 0 && n_tests < MAX_TESTS) begin
			if (line.len() == 0 || line.getc(0) == "#") continue;
			if ($sscanf(line, "%s %h %h %d %d", nm, a, d, w, g) == 5) begin
				t_name[n_tests] = nm;
				t_adr[n_tests] = a;
				t_dat[n_tests] = d;
				t_wait[n_tests] = w;
				t_gap[n_tests] = g;
				n_tests++;
			end
		end
		$fclose(fd);

		repeat (3) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;
		@(negedge clk);
		check_val(cur_name, "cmd_ready", 1, cmd_ready);
		check_val(cur_name, "busy", 0, busy);
		check_val(cur_name, "wb_cyc", 0, wb_cyc);
		check_val(cur_name, "timeout_err", 0, timeout_err);
		check_val(cur_name, "fill_count", 0, fill_count);
		finish_test(cur_name);

		// a group is one entry with a gap plus the back-to-back entries after it
		i = 0;
		while (i < n_tests) begin
			grp_end = i + 1;
			while (grp_end < n_tests && t_gap[grp_end] == 0) grp_end++;
			cur_name = t_name[i];
			wait_idle();
			repeat (t_gap[i]) @(negedge clk);
			max_fill = 0;
			ready_fell = 1'b0;
			for (k = i; k < grp_end; k++) begin
				push_cmd(k);
				if (k == i) first_push = push_edge;
			end
			wait_cycles(grp_end);
			for (k = i; k < grp_end; k++) begin
				cur_name = t_name[k];
				if (k == i) begin
					check_val(cur_name, "stb latency", LAT_EDGES, rise_q[k] - first_push + 1);
				end
				if (t_wait[k] == NO_ACK) begin
					hang_seen = 1'b1;
					check_val(cur_name, "acknowledged", 0, c_ack[k]);
					check_val(cur_name, "stb cycles", `CQ_WAIT_LIMIT, c_len[k]);
				end else begin
					check_val(cur_name, "acknowledged", 1, c_ack[k]);
					check_val(cur_name, "wb_adr", t_adr[k], c_adr[k]);
					check_val(cur_name, "wb_dat_o", t_dat[k], c_dat[k]);
					if (t_wait[k] != RAND_ACK) begin
						check_val(cur_name, "stb cycles", t_wait[k] + 1, c_len[k]);
					end
				end
				// sticky once a write was abandoned
				check_val(cur_name, "timeout_err", hang_seen, timeout_err);
				if (grp_end - i >= 3 && k == grp_end - 1) begin
					check_val(cur_name, "max fill_count", 2, max_fill);
					check_val(cur_name, "cmd_ready fell", 1, ready_fell);
				end
				finish_test(cur_name);
			end
			i = grp_end;
		end

		if (DUT.u_props.fail_cnt != 0) begin
			$display("bus protocol assertions failed %0d times", DUT.u_props.fail_cnt);
			total_errs += DUT.u_props.fail_cnt;
		end
		$display("tests passed %0d, failed %0d, errors %0d", passed, failed, total_errs);
		if (total_errs == 0) begin
			$display("RESULT: PASS");
		end else begin
			$display("RESULT: FAIL");
		end
		$finish;
	end

endmodule
